/* rv_pkg.sv */
package rv_pkg;

    localparam int WORD_WIDTH     = 32;
    localparam int PC_WIDTH       = 32;
    localparam int GPR_ADDR_WIDTH = 5;

    typedef logic [GPR_ADDR_WIDTH-1:0] gpr_addr_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;

    // rv32i major opcodes in use
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLT   = 3'd5,
        // result is alu_in_1 unchanged
        ALU_PASS1 = 3'd6
    } alu_op_t;

endpackage

/* pipe_if.sv */
`timescale 1ns/10ps

// decoded instruction, ID to EX
interface dec_bus import rv_pkg::*; ();
    logic      valid;
    alu_op_t   alu_op;
    word_t     alu_in_0;
    word_t     alu_in_1;
    gpr_addr_t dst_addr;
    logic      gpr_we;
    logic      mem_we;
    logic      mem_rd;
    word_t     store_data;

    modport src (output valid, alu_op, alu_in_0, alu_in_1, dst_addr,
                 output gpr_we, mem_we, mem_rd, store_data);
    modport dst (input valid, alu_op, alu_in_0, alu_in_1, dst_addr,
                 input gpr_we, mem_we, mem_rd, store_data);
endinterface

// results of EX, MEM and WB back to ID
interface fwd_bus import rv_pkg::*; ();
    gpr_addr_t ex_dst_addr;
    logic      ex_we;
    logic      ex_is_load;
    word_t     ex_result;
    gpr_addr_t mem_dst_addr;
    logic      mem_we;
    logic      mem_is_load;
    word_t     mem_result;
    gpr_addr_t wb_dst_addr;
    logic      wb_we;
    word_t     wb_data;

    modport src (output ex_dst_addr, ex_we, ex_is_load, ex_result,
                 output mem_dst_addr, mem_we, mem_is_load, mem_result,
                 output wb_dst_addr, wb_we, wb_data);
    modport dst (input ex_dst_addr, ex_we, ex_is_load, ex_result,
                 input mem_dst_addr, mem_we, mem_is_load, mem_result,
                 input wb_dst_addr, wb_we, wb_data);
endinterface

/* fetch.sv */
`timescale 1ns/10ps

module fetch import rv_pkg::*; #(
    parameter logic [PC_WIDTH-1:0] RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cpu_en,
    input  logic  stall,
    input  logic  flush,
    input  logic  br_taken,
    input  word_t br_addr,
    input  word_t insn,
    output word_t pc,
    output word_t if_pc,
    output word_t if_insn,
    output logic  if_valid
);

    logic [PC_WIDTH-1:0] pc_next;

    assign pc_next = br_taken ? br_addr : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (cpu_en && !stall) begin
            pc <= pc_next;
        end
    end

    // flushed slot becomes a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else if (cpu_en && !stall) begin
            if_valid <= !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en && !stall) begin
            if_pc   <= pc;
            if_insn <= insn;
        end
    end

endmodule

/* decoder.sv */
`timescale 1ns/10ps

module decoder import rv_pkg::*; (
    input  word_t     if_pc,
    input  word_t     if_insn,
    input  logic      if_valid,
    output gpr_addr_t rd_addr_0,
    output gpr_addr_t rd_addr_1,
    input  word_t     rd_data_0,
    input  word_t     rd_data_1,
    fwd_bus.dst       fwd,
    dec_bus.src       dec,
    output logic      br_taken,
    output word_t     br_addr,
    output logic      stall,
    output logic      flush
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      src_0;
    word_t      src_1;
    logic       legal;
    logic       use_0;
    logic       use_1;
    logic       branch;
    logic       jump;
    logic       br_cond;

    // youngest non-load result wins, x0 is never forwarded
    function automatic word_t forward(input gpr_addr_t addr, input word_t rf_data);
        word_t val;
        val = rf_data;
        if (addr != '0) begin
            if (fwd.ex_we && !fwd.ex_is_load && fwd.ex_dst_addr == addr) begin
                val = fwd.ex_result;
            end else if (fwd.mem_we && !fwd.mem_is_load && fwd.mem_dst_addr == addr) begin
                val = fwd.mem_result;
            end else if (fwd.wb_we && fwd.wb_dst_addr == addr) begin
                val = fwd.wb_data;
            end
        end
        return val;
    endfunction

    function automatic logic reads(input gpr_addr_t dst);
        return dst != '0 && ((use_0 && dst == rd_addr_0) || (use_1 && dst == rd_addr_1));
    endfunction

    assign opcode    = opcode_t'(if_insn[6:0]);
    assign funct3    = if_insn[14:12];
    assign funct7    = if_insn[31:25];
    assign rd_addr_0 = if_insn[19:15];
    assign rd_addr_1 = if_insn[24:20];

    assign imm_i = {{20{if_insn[31]}}, if_insn[31:20]};
    assign imm_s = {{20{if_insn[31]}}, if_insn[31:25], if_insn[11:7]};
    assign imm_b = {{19{if_insn[31]}}, if_insn[31], if_insn[7], if_insn[30:25],
                    if_insn[11:8], 1'b0};
    assign imm_u = {if_insn[31:12], 12'b0};
    assign imm_j = {{11{if_insn[31]}}, if_insn[31], if_insn[19:12], if_insn[20],
                    if_insn[30:21], 1'b0};

    assign src_0 = forward(rd_addr_0, rd_data_0);
    assign src_1 = forward(rd_addr_1, rd_data_1);

    always_comb begin
        legal        = 1'b0;
        use_0        = 1'b0;
        use_1        = 1'b0;
        branch       = 1'b0;
        jump         = 1'b0;
        dec.alu_op   = ALU_ADD;
        dec.alu_in_0 = src_0;
        dec.alu_in_1 = imm_i;
        dec.gpr_we   = 1'b0;
        dec.mem_we   = 1'b0;
        dec.mem_rd   = 1'b0;
        case (opcode)
            OP_LUI: begin
                legal        = 1'b1;
                dec.alu_op   = ALU_PASS1;
                dec.alu_in_1 = imm_u;
                dec.gpr_we   = 1'b1;
            end
            OP_IMM: begin
                legal      = funct3 == 3'b000;
                use_0      = 1'b1;
                dec.gpr_we = 1'b1;
            end
            OP_REG: begin
                legal        = funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000);
                use_0        = 1'b1;
                use_1        = 1'b1;
                dec.alu_in_1 = src_1;
                dec.gpr_we   = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OP_LOAD: begin
                legal      = funct3 == 3'b010;
                use_0      = 1'b1;
                dec.gpr_we = 1'b1;
                dec.mem_rd = 1'b1;
            end
            OP_STORE: begin
                legal        = funct3 == 3'b010;
                use_0        = 1'b1;
                use_1        = 1'b1;
                dec.alu_in_1 = imm_s;
                dec.mem_we   = 1'b1;
            end
            OP_BRANCH: begin
                legal  = funct3[2:1] == 2'b00;
                use_0  = 1'b1;
                use_1  = 1'b1;
                branch = 1'b1;
            end
            OP_JAL: begin
                // link value pc + 4 through the alu
                legal        = 1'b1;
                jump         = 1'b1;
                dec.alu_in_0 = if_pc;
                dec.alu_in_1 = 32'd4;
                dec.gpr_we   = 1'b1;
            end
            default: ;
        endcase
    end

    assign dec.valid      = if_valid && legal;
    assign dec.dst_addr   = if_insn[11:7];
    assign dec.store_data = src_1;

    // funct3[0] set means bne
    assign br_cond  = funct3[0] ? src_0 != src_1 : src_0 == src_1;
    assign br_taken = dec.valid && (jump || (branch && br_cond));
    assign br_addr  = if_pc + (jump ? imm_j : imm_b);

    // load in EX costs two cycles, load in MEM one
    assign stall = if_valid && ((fwd.ex_we && fwd.ex_is_load && reads(fwd.ex_dst_addr)) ||
                                (fwd.mem_we && fwd.mem_is_load && reads(fwd.mem_dst_addr)));
    assign flush = br_taken && !stall;

endmodule

/* gpr.sv */
`timescale 1ns/10ps

module gpr import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_en,
    input  logic      we,
    input  gpr_addr_t wr_addr,
    input  word_t     wr_data,
    input  gpr_addr_t rd_addr_0,
    input  gpr_addr_t rd_addr_1,
    output word_t     rd_data_0,
    output word_t     rd_data_1
);

    // x0 has no storage
    word_t regs [1:2**GPR_ADDR_WIDTH-1];

    function automatic word_t read_port(input gpr_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (we && addr == wr_addr) begin
            val = wr_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**GPR_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (cpu_en && we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_0 = read_port(rd_addr_0);
    assign rd_data_1 = read_port(rd_addr_1);

endmodule

/* execute.sv */
`timescale 1ns/10ps

module execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_en,
    input  logic      stall,
    dec_bus.dst       dec,
    fwd_bus.src       fwd,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic      mem_we,
    output logic      mem_rd,
    output gpr_addr_t mem_dst_addr,
    output logic      mem_gpr_we
);

    alu_op_t   id_alu_op;
    word_t     id_alu_in_0;
    word_t     id_alu_in_1;
    word_t     id_store_data;
    gpr_addr_t id_dst_addr;
    logic      id_gpr_we;
    logic      id_mem_we;
    logic      id_mem_rd;
    word_t     alu_out;

    // ID register, bubble on stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_gpr_we <= 1'b0;
            id_mem_we <= 1'b0;
            id_mem_rd <= 1'b0;
        end else if (cpu_en) begin
            id_gpr_we <= dec.valid && dec.gpr_we && !stall;
            id_mem_we <= dec.valid && dec.mem_we && !stall;
            id_mem_rd <= dec.valid && dec.mem_rd && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            id_alu_op     <= dec.alu_op;
            id_alu_in_0   <= dec.alu_in_0;
            id_alu_in_1   <= dec.alu_in_1;
            id_store_data <= dec.store_data;
            id_dst_addr   <= dec.dst_addr;
        end
    end

    always_comb begin
        case (id_alu_op)
            ALU_ADD:   alu_out = id_alu_in_0 + id_alu_in_1;
            ALU_SUB:   alu_out = id_alu_in_0 - id_alu_in_1;
            ALU_AND:   alu_out = id_alu_in_0 & id_alu_in_1;
            ALU_OR:    alu_out = id_alu_in_0 | id_alu_in_1;
            ALU_XOR:   alu_out = id_alu_in_0 ^ id_alu_in_1;
            ALU_SLT:   alu_out = word_t'($signed(id_alu_in_0) < $signed(id_alu_in_1));
            ALU_PASS1: alu_out = id_alu_in_1;
            default:   alu_out = '0;
        endcase
    end

    // EX register, feeds the MEM stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_we     <= 1'b0;
            mem_rd     <= 1'b0;
            mem_gpr_we <= 1'b0;
        end else if (cpu_en) begin
            mem_we     <= id_mem_we;
            mem_rd     <= id_mem_rd;
            mem_gpr_we <= id_gpr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            mem_addr     <= alu_out;
            mem_wdata    <= id_store_data;
            mem_dst_addr <= id_dst_addr;
        end
    end

    assign fwd.ex_dst_addr  = id_dst_addr;
    assign fwd.ex_we        = id_gpr_we;
    assign fwd.ex_is_load   = id_mem_rd;
    assign fwd.ex_result    = alu_out;
    assign fwd.mem_dst_addr = mem_dst_addr;
    assign fwd.mem_we       = mem_gpr_we;
    assign fwd.mem_is_load  = mem_rd;
    assign fwd.mem_result   = mem_addr;

endmodule

/* mem_wb.sv */
`timescale 1ns/10ps

module mem_wb import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_en,
    input  word_t     mem_addr,
    input  word_t     mem_wdata,
    input  logic      mem_we,
    input  logic      mem_rd,
    input  gpr_addr_t mem_dst_addr,
    input  logic      mem_gpr_we,
    output word_t     d_addr,
    output word_t     d_wdata,
    output logic      d_we,
    output logic      d_re,
    input  word_t     d_rdata,
    fwd_bus.src       fwd,
    output logic      wb_we,
    output gpr_addr_t wb_addr,
    output word_t     wb_data
);

    word_t wb_result;
    logic  wb_load;

    // no strobes while paused
    assign d_addr  = mem_addr;
    assign d_wdata = mem_wdata;
    assign d_we    = cpu_en && mem_we;
    assign d_re    = cpu_en && mem_rd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we   <= 1'b0;
            wb_load <= 1'b0;
        end else if (cpu_en) begin
            wb_we   <= mem_gpr_we;
            wb_load <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            wb_addr   <= mem_dst_addr;
            wb_result <= mem_addr;
        end
    end

    // load data arrives one cycle after d_re
    assign wb_data = wb_load ? d_rdata : wb_result;

    assign fwd.wb_dst_addr = wb_addr;
    assign fwd.wb_we       = wb_we;
    assign fwd.wb_data     = wb_data;

endmodule

/* pipeline_cpu_top.sv */
`timescale 1ns/10ps

module pipeline_cpu_top import rv_pkg::*; #(
    parameter logic [PC_WIDTH-1:0] RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cpu_en,
    input  word_t insn,
    output word_t pc,
    output logic  rd_insn_en,
    output word_t d_addr,
    output word_t d_wdata,
    output logic  d_we,
    output logic  d_re,
    input  word_t d_rdata
);

    word_t     if_pc;
    word_t     if_insn;
    logic      if_valid;
    logic      br_taken;
    word_t     br_addr;
    logic      stall;
    logic      flush;
    gpr_addr_t rd_addr_0;
    gpr_addr_t rd_addr_1;
    word_t     rd_data_0;
    word_t     rd_data_1;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_we;
    logic      mem_rd;
    gpr_addr_t mem_dst_addr;
    logic      mem_gpr_we;
    logic      wb_we;
    gpr_addr_t wb_addr;
    word_t     wb_data;

    dec_bus u_dec_bus ();
    fwd_bus u_fwd_bus ();

    assign rd_insn_en = cpu_en;

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_en   (cpu_en),
        .stall    (stall),
        .flush    (flush),
        .br_taken (br_taken),
        .br_addr  (br_addr),
        .insn     (insn),
        .pc       (pc),
        .if_pc    (if_pc),
        .if_insn  (if_insn),
        .if_valid (if_valid)
    );

    decoder u_decoder (
        .if_pc     (if_pc),
        .if_insn   (if_insn),
        .if_valid  (if_valid),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1),
        .fwd       (u_fwd_bus.dst),
        .dec       (u_dec_bus.src),
        .br_taken  (br_taken),
        .br_addr   (br_addr),
        .stall     (stall),
        .flush     (flush)
    );

    gpr u_gpr (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_en    (cpu_en),
        .we        (wb_we),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

    execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_en       (cpu_en),
        .stall        (stall),
        .dec          (u_dec_bus.dst),
        .fwd          (u_fwd_bus.src),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .mem_rd       (mem_rd),
        .mem_dst_addr (mem_dst_addr),
        .mem_gpr_we   (mem_gpr_we)
    );

    mem_wb u_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_en       (cpu_en),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .mem_rd       (mem_rd),
        .mem_dst_addr (mem_dst_addr),
        .mem_gpr_we   (mem_gpr_we),
        .d_addr       (d_addr),
        .d_wdata      (d_wdata),
        .d_we         (d_we),
        .d_re         (d_re),
        .d_rdata      (d_rdata),
        .fwd          (u_fwd_bus.src),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

endmodule

/* tb_pipeline_cpu.sv */
`timescale 1ns/10ps

module tb_pipeline_cpu;

    localparam logic [31:0] RESET_PC = 32'h0000_0040;
    localparam int          TIMEOUT  = 2000;
    localparam logic [31:0] NOP      = 32'h0000_0013;

    logic        clk;
    logic        rst_n   = 1'b0;
    logic        cpu_en  = 1'b0;
    logic [31:0] insn;
    logic [31:0] pc;
    logic        rd_insn_en;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic        d_we;
    logic        d_re;
    logic [31:0] d_rdata = '0;

    logic [31:0] rom  [256];
    logic [31:0] dmem [256];
    logic [31:0] prog_pc;
    logic [31:0] st_addr[$];
    logic [31:0] st_data[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    logic [15:0] lfsr   = 16'd3633;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    pipeline_cpu_top #(
        .RESET_PC (RESET_PC)
    ) u_pipeline_cpu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_en     (cpu_en),
        .insn       (insn),
        .pc         (pc),
        .rd_insn_en (rd_insn_en),
        .d_addr     (d_addr),
        .d_wdata    (d_wdata),
        .d_we       (d_we),
        .d_re       (d_re),
        .d_rdata    (d_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign insn = rom[pc[9:2]];

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5a, a};
    endfunction

    // data memory, refilled on every reset, plus the store log
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i[7:0]);
            end
        end else begin
            if (d_we) begin
                dmem[d_addr[9:2]] <= d_wdata;
                st_addr.push_back(d_addr);
                st_data.push_back(d_wdata);
            end
            if (d_re) begin
                d_rdata <= dmem[d_addr[9:2]];
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout, run stopped after %0d cycles with %0d errors", cycles, errors);
            $display("Checks failed");
            $finish;
        end
    end

    // galois lfsr, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic clear_rom();
        for (int i = 0; i < 256; i++) begin
            rom[i] = NOP;
        end
        prog_pc = RESET_PC;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input logic [31:0] word);
        rom[prog_pc[9:2]] = word;
        prog_pc = prog_pc + 32'd4;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic apply_reset(input string name);
        @(posedge clk);
        rst_n  <= 1'b0;
        // run gate open, strobes must stay low from reset alone
        cpu_en <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst_n  <= 1'b1;
                cpu_en <= 1'b0;
            end
            @(negedge clk);
            checks++;
            if (pc !== RESET_PC) begin
                errors++;
                $display("Fail %s: expected pc %h, actual %h", name, RESET_PC, pc);
            end
            if (d_we !== 1'b0 || d_re !== 1'b0) begin
                errors++;
                $display("Fail %s: expected d_we 0 d_re 0, actual d_we %b d_re %b",
                         name, d_we, d_re);
            end
        end
    endtask

    task automatic pause_cpu();
        logic [31:0] held_pc;
        int          held_stores;
        @(posedge clk);
        cpu_en <= 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (i == 0) begin
                held_pc     = pc;
                held_stores = st_addr.size();
            end
            checks++;
            if (pc !== held_pc) begin
                errors++;
                $display("Fail pause: expected pc %h, actual %h", held_pc, pc);
            end
            if (rd_insn_en !== 1'b0 || d_we !== 1'b0 || d_re !== 1'b0) begin
                errors++;
                $display("Fail pause: expected rd_insn_en d_we d_re 000, actual %b%b%b",
                         rd_insn_en, d_we, d_re);
            end
            if (st_addr.size() != held_stores) begin
                errors++;
                $display("pause: a store reached the data port while cpu_en was low");
            end
        end
        @(posedge clk);
        cpu_en <= 1'b1;
    endtask

    // runs until n_stores stores are logged, then a few more cycles
    task automatic run_program(input int n_stores, input int pause_at);
        st_addr.delete();
        st_data.delete();
        @(posedge clk);
        cpu_en <= 1'b1;
        while (st_addr.size() < n_stores) begin
            @(negedge clk);
            if (pause_at > 0 && st_addr.size() == pause_at) begin
                pause_cpu();
                pause_at = 0;
            end
        end
        repeat (10) @(negedge clk);
        @(posedge clk);
        cpu_en <= 1'b0;
    endtask

    task automatic check_log(input string name);
        checks++;
        if (st_addr.size() != exp_addr.size()) begin
            errors++;
            $display("Fail %s: expected %0d stores, actual %0d",
                     name, exp_addr.size(), st_addr.size());
        end else begin
            foreach (exp_addr[i]) begin
                checks++;
                if (st_addr[i] !== exp_addr[i] || st_data[i] !== exp_data[i]) begin
                    errors++;
                    $display("Fail %s: store %0d expected [%h]=%h, actual [%h]=%h", name, i,
                             exp_addr[i], exp_data[i], st_addr[i], st_data[i]);
                end
            end
        end
    endtask

    task automatic test_reset();
        apply_reset("reset");
        @(negedge clk);
        checks++;
        if (pc !== RESET_PC) begin
            errors++;
            $display("Fail reset: expected pc %h, actual %h", RESET_PC, pc);
        end
    endtask

    task automatic test_alu();
        logic [31:0] u;
        logic [31:0] i1;
        logic [31:0] i2;
        logic [31:0] r [1:8];
        clear_rom();
        u  = rand_bits(20);
        i1 = rand_bits(12);
        i2 = rand_bits(12);
        r[1] = {u[19:0], 12'b0} + sext12(i1[11:0]);
        r[2] = r[1] + sext12(i2[11:0]);
        r[3] = r[2] + r[1];
        r[4] = r[3] - r[2];
        r[5] = r[4] & r[3];
        r[6] = r[5] | r[2];
        r[7] = r[6] ^ r[1];
        r[8] = ($signed(r[7]) < $signed(r[3])) ? 32'd1 : 32'd0;
        emit(enc_lui(5'd1, u[19:0]));
        emit(enc_addi(5'd1, 5'd1, i1[11:0]));
        emit(enc_addi(5'd2, 5'd1, i2[11:0]));
        emit(enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));
        emit(enc_r(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        emit(enc_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
        emit(enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd1));
        emit(enc_r(7'h00, 3'b010, 5'd8, 5'd7, 5'd3));
        // youngest result first, so stores see EX, MEM and WB forwarding
        for (int k = 8; k >= 1; k--) begin
            emit(enc_sw(5'(k), 12'(32'h100 + 4 * (8 - k))));
            expect_store(32'h100 + 4 * (8 - k), r[k]);
        end
        apply_reset("alu");
        run_program(8, 0);
        check_log("alu");
    endtask

    task automatic build_load_use();
        logic [31:0] v;
        logic [31:0] w;
        clear_rom();
        v = rand_bits(12);
        w = rand_bits(12);
        emit(enc_addi(5'd1, 5'd0, v[11:0]));
        emit(enc_sw(5'd1, 12'h040));
        emit(enc_lw(5'd2, 12'h040));
        emit(enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(enc_sw(5'd3, 12'h044));
        emit(enc_lw(5'd4, 12'h044));
        // one unrelated slot between load and use
        emit(enc_addi(5'd5, 5'd0, w[11:0]));
        emit(enc_r(7'h00, 3'b000, 5'd6, 5'd4, 5'd5));
        emit(enc_sw(5'd6, 12'h048));
        expect_store(32'h40, sext12(v[11:0]));
        expect_store(32'h44, sext12(v[11:0]) + sext12(v[11:0]));
        expect_store(32'h48, sext12(v[11:0]) + sext12(v[11:0]) + sext12(w[11:0]));
    endtask

    task automatic test_load_use();
        build_load_use();
        apply_reset("load_use");
        run_program(3, 0);
        check_log("load_use");
    endtask

    task automatic test_branch();
        logic [31:0] v;
        logic [31:0] jal_pc;
        clear_rom();
        v = rand_bits(12);
        emit(enc_addi(5'd1, 5'd0, v[11:0]));
        emit(enc_addi(5'd2, 5'd0, v[11:0]));
        emit(enc_branch(3'b000, 5'd1, 5'd2, 13'd8));
        emit(enc_sw(5'd1, 12'h080));
        emit(enc_sw(5'd2, 12'h084));
        emit(enc_branch(3'b001, 5'd1, 5'd2, 13'd8));
        emit(enc_sw(5'd1, 12'h088));
        jal_pc = prog_pc;
        emit(enc_jal(5'd3, 21'd12));
        emit(enc_sw(5'd1, 12'h08c));
        emit(enc_sw(5'd1, 12'h090));
        emit(enc_sw(5'd3, 12'h094));
        expect_store(32'h84, sext12(v[11:0]));
        expect_store(32'h88, sext12(v[11:0]));
        expect_store(32'h94, jal_pc + 32'd4);
        apply_reset("branch");
        run_program(3, 0);
        check_log("branch");
    endtask

    // same stores as the uninterrupted load-use program
    task automatic test_pause();
        build_load_use();
        apply_reset("pause");
        run_program(3, 1);
        check_log("pause");
    endtask

    initial begin
        clear_rom();
        test_reset();
        test_alu();
        test_load_use();
        test_branch();
        test_pause();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
rv_pkg.sv
pipe_if.sv
fetch.sv
decoder.sv
gpr.sv
execute.sv
mem_wb.sv
pipeline_cpu_top.sv
tb_pipeline_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
verilator --binary -f vlog.f --top-module tb_pipeline_cpu -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi
./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
